// ==== cache_top.f ====
logic/cache_pkg.sv
logic/cache_way.sv
logic/lru_tracker.sv
logic/data_align.sv
logic/cache_top.sv
tb/cache_properties.sv
tb/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f cache_top.f -o cache_sim
./obj_dir/cache_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"

// ==== tb/cache_tb.sv ====
/* Cache array testbench
   Directed and seeded random commands checked against a reference model */

`timescale 1ns/1ps

module cache_tb;

    localparam int SET_BITS = 4;
    localparam int NUM_SETS = 2 ** SET_BITS;
    localparam int TAG_W    = 32 - SET_BITS - 4;

    // Command strobes as {invalid, replace, store, load}
    localparam logic [3:0] C_NONE  = 4'b0000;
    localparam logic [3:0] C_LOAD  = 4'b0001;
    localparam logic [3:0] C_STORE = 4'b0010;
    localparam logic [3:0] C_REPL  = 4'b0100;
    localparam logic [3:0] C_INVAL = 4'b1000;

    logic                  clk;
    logic                  rst;
    cache_pkg::addr_t      addr;
    logic                  load;
    logic                  store;
    logic                  replace;
    logic                  invalid;
    cache_pkg::width_sel_t width_sel;
    cache_pkg::word_t      din;
    logic                  hit;
    logic                  valid;
    logic                  dirty;
    logic [TAG_W-1:0]      tag;
    cache_pkg::word_t      dout;

    // Reference model, indexed [set][way] and [set][way][word]
    logic [TAG_W-1:0] m_tag   [NUM_SETS][4];
    logic             m_valid [NUM_SETS][4] = '{default: '{default: 1'b0}};
    logic             m_dirty [NUM_SETS][4] = '{default: '{default: 1'b0}};
    int               m_age   [NUM_SETS][4] = '{default: '{default: 0}};
    logic [31:0]      m_data  [NUM_SETS][4][4];
    logic             m_known [NUM_SETS][4][4] = '{default: '{default: '{default: 1'b0}}};

    int    seed        = 96749;
    int    errors      = 0;
    int    checks      = 0;
    int    test_errors = 0;
    string test_name;

    cache_top #(.SET_BITS(SET_BITS)) u_dut (
        .clk(clk), .rst(rst), .addr(addr), .load(load), .store(store), .replace(replace),
        .invalid(invalid), .width_sel(width_sel), .din(din), .hit(hit), .valid(valid),
        .dirty(dirty), .tag(tag), .dout(dout)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #200000;  // Far beyond the longest command stream
        $display("Timeout, the command sequence did not complete");
        $display("Test failures found");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic int rnd(input int n);
        int r;
        r = $random(seed);
        return int'((r & 32'h7fff_ffff) % n);
    endfunction

    function automatic logic [31:0] make_addr(input int tg, input int s, input int wi,
                                              input int off);
        return {TAG_W'(tg), SET_BITS'(s), 2'(wi), 2'(off)};
    endfunction

    // Lowest hit way, else lowest way of minimum age
    function automatic int pick_way(input int s, input logic [TAG_W-1:0] t);
        int v;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) return w;
        end
        v = 0;
        for (int w = 1; w < 4; w++) begin
            if (m_age[s][w] < m_age[s][v]) v = w;
        end
        return v;
    endfunction

    function automatic logic [31:0] extract(input logic [31:0] w, input int off,
                                            input logic [2:0] ws);
        logic [31:0] b;
        logic [31:0] hw;
        b  = w >> (8 * off);
        hw = w >> (16 * (off / 2));  // Aligned half holding the byte
        if (ws[1]) return w;
        if (ws[0]) return ws[2] ? {16'h0, hw[15:0]} : {{16{hw[15]}}, hw[15:0]};
        return ws[2] ? {24'h0, b[7:0]} : {{24{b[7]}}, b[7:0]};
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] w, input int off,
                                          input logic [2:0] ws, input logic [31:0] d);
        logic [31:0] mask;
        int          sh;
        if (ws[1]) return d;
        sh   = ws[0] ? 16 * (off / 2) : 8 * off;
        mask = (ws[0] ? 32'h0000_ffff : 32'h0000_00ff) << sh;
        return (w & ~mask) | ((d << sh) & mask);
    endfunction

    // One command cycle: drive, compare with the model, then advance the model
    task automatic step(input logic [3:0] cmd, input logic [31:0] a, input logic [2:0] ws,
                        input logic [31:0] d);
        int               s;
        int               wi;
        int               off;
        int               v;
        int               old;
        logic [TAG_W-1:0] t;
        logic             h;
        logic [31:0]      exp_dout;
        s   = int'(a[4 +: SET_BITS]);
        wi  = int'(a[3:2]);
        off = int'(a[1:0]);
        t   = a[31 -: TAG_W];
        @(negedge clk);
        addr = a;
        width_sel = ws;
        din = d;
        {invalid, replace, store, load} = cmd;
        #5;  // Combinational outputs settled, rising edge still ahead
        v = pick_way(s, t);
        h = m_valid[s][v] && (m_tag[s][v] == t);
        check("hit", 32'(h), 32'(hit));
        check("valid", 32'(m_valid[s][v]), 32'(valid));
        check("dirty", 32'(m_dirty[s][v]), 32'(dirty));
        if (m_valid[s][v]) begin
            check("tag", 32'(m_tag[s][v]), 32'(tag));
            if (m_known[s][v][wi]) begin
                exp_dout = (cmd == C_LOAD && h) ? extract(m_data[s][v][wi], off, ws)
                                                : m_data[s][v][wi];
                check("dout", exp_dout, dout);
            end
        end
        if (cmd == C_INVAL) begin
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = 0;
            end
        end else if (cmd == C_REPL || (h && cmd != C_NONE)) begin
            old = m_age[s][v];
            for (int w = 0; w < 4; w++) begin
                if (m_age[s][w] > old) m_age[s][w]--;  // Younger ways shift down
            end
            m_age[s][v] = 3;
            if (cmd == C_REPL) begin
                m_tag[s][v]       = t;
                m_valid[s][v]     = 1'b1;
                m_dirty[s][v]     = 1'b0;
                m_data[s][v][wi]  = d;
                m_known[s][v][wi] = 1'b1;
            end else if (cmd == C_STORE) begin
                m_data[s][v][wi]  = merge(m_data[s][v][wi], off, ws, d);
                m_dirty[s][v]     = 1'b1;
                m_known[s][v][wi] = m_known[s][v][wi] || ws[1];
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test;
        $display("%-14s %s, %0d errors", test_name,
                 (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    endtask

    initial begin
        int         sel;
        logic [3:0] cmd;
        rst = 1'b1;
        addr = '0;
        {invalid, replace, store, load} = C_NONE;
        width_sel = 3'd2;
        din = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset_state");
        repeat (20) step(C_NONE, make_addr(rnd(64), rnd(16), rnd(4), rnd(4)), 3'd2, 0);
        finish_test();

        start_test("replace_load");
        for (int i = 0; i < 4; i++) begin
            step(C_REPL, make_addr(5, 3, i, 0), 3'd2, $random(seed));
            for (int ws = 0; ws < 8; ws++) begin
                for (int off = 0; off < 4; off++) begin
                    step(C_LOAD, make_addr(5, 3, i, off), 3'(ws), 0);
                end
            end
        end
        finish_test();

        start_test("store_merge");
        step(C_REPL, make_addr(6, 5, 1, 0), 3'd2, $random(seed));
        for (int ws = 0; ws < 3; ws++) begin
            for (int off = 0; off < 4; off++) begin
                step(C_STORE, make_addr(6, 5, 1, off), 3'(ws), $random(seed));
                step(C_LOAD, make_addr(6, 5, 1, 0), 3'd2, 0);  // Merged word, dirty high
            end
        end
        finish_test();

        start_test("lru_eviction");
        for (int k = 0; k < 5; k++) begin
            step(C_REPL, make_addr(10 + k, 9, 0, 0), 3'd2, $random(seed));
            step(C_LOAD, make_addr(10, 9, 0, 0), 3'd2, 0);  // Keeps tag 10 young
        end
        for (int k = 0; k < 5; k++) step(C_NONE, make_addr(10 + k, 9, 0, 0), 3'd2, 0);
        finish_test();

        start_test("invalidate");
        for (int k = 0; k < 3; k++) begin
            step(C_REPL, make_addr(20 + k, 2, k, 0), 3'd2, $random(seed));
            step(C_REPL, make_addr(20 + k, 7, k, 0), 3'd2, $random(seed));
        end
        step(C_INVAL, make_addr(20, 2, 0, 0), 3'd2, 0);
        for (int k = 0; k < 3; k++) begin
            step(C_LOAD, make_addr(20 + k, 2, k, 0), 3'd2, 0);
            step(C_LOAD, make_addr(20 + k, 7, k, 0), 3'd2, 0);
        end
        finish_test();

        start_test("random_mix");
        for (int i = 0; i < 2000; i++) begin
            sel = rnd(20);
            cmd = (sel < 6) ? C_LOAD : (sel < 10) ? C_STORE : (sel < 15) ? C_REPL :
                  (sel == 15) ? C_INVAL : C_NONE;
            step(cmd, make_addr(rnd(6), rnd(4), rnd(4), rnd(4)), 3'(rnd(8)), $random(seed));
        end
        finish_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb/cache_properties.sv ====
/* Cache array properties
   Hit, reset and fill consistency checks bound onto the top level */

`timescale 1ns/1ps

module cache_properties (
    input logic             clk,
    input logic             rst,
    input cache_pkg::addr_t addr,
    input logic             replace,
    input logic             invalid,
    input logic             hit,
    input logic             valid,
    input logic             dirty
);

    // A hit always comes from a valid line
    a_hit_valid: assert property (@(posedge clk) disable iff (rst) hit |-> valid)
        else $error("hit asserted on an invalid line");

    a_reset_miss: assert property (@(posedge clk) $fell(rst) |-> !hit)
        else $error("hit high in the first cycle after reset");

    // Freshly filled line is found clean one cycle later
    a_fill_hit: assert property (@(posedge clk) disable iff (rst)
        ($past(replace) && !$past(invalid) && addr == $past(addr)) |-> (hit && !dirty))
        else $error("replaced line missing or dirty on the next cycle");

endmodule

bind cache_top cache_properties u_props (
    .clk(clk), .rst(rst), .addr(addr), .replace(replace), .invalid(invalid),
    .hit(hit), .valid(valid), .dirty(dirty)
);

// ==== logic/cache_top.sv ====
/* Four way set associative data cache array
   Address split, command decode, way storage and output selection */

`timescale 1ns/1ps

module cache_top #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::addr_t      addr,
    input  logic                  load,
    input  logic                  store,
    input  logic                  replace,
    input  logic                  invalid,
    input  cache_pkg::width_sel_t width_sel,
    input  cache_pkg::word_t      din,
    output logic                  hit,
    output logic                  valid,
    output logic                  dirty,
    output logic [cache_pkg::ADDR_W-SET_BITS-cache_pkg::OFFSET_BITS
                  -cache_pkg::WORD_SEL_BITS-1:0] tag,
    output cache_pkg::word_t      dout
);

    localparam int LINE_LSB = cache_pkg::OFFSET_BITS + cache_pkg::WORD_SEL_BITS;
    localparam int TAG_W    = cache_pkg::ADDR_W - SET_BITS - LINE_LSB;
    localparam int NUM_WAYS = cache_pkg::NUM_WAYS;

    logic [TAG_W-1:0]                  addr_tag;
    logic [SET_BITS-1:0]               set_idx;
    cache_pkg::word_sel_t              word_sel;
    logic [cache_pkg::OFFSET_BITS-1:0] offset;

    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_dirty;
    logic [TAG_W-1:0]    way_tag  [NUM_WAYS];
    cache_pkg::word_t    way_word [NUM_WAYS];

    cache_pkg::way_idx_t chosen_way;
    cache_pkg::word_t    line_word;
    cache_pkg::word_t    load_data;
    cache_pkg::word_t    store_word;
    cache_pkg::word_t    wr_data;

    logic do_inval;
    logic do_fill;
    logic do_store;
    logic do_load;
    logic touch;

    // Address fields
    assign addr_tag = addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign set_idx  = addr[LINE_LSB +: SET_BITS];
    assign word_sel = addr[cache_pkg::OFFSET_BITS +: cache_pkg::WORD_SEL_BITS];
    assign offset   = addr[cache_pkg::OFFSET_BITS-1:0];

    // Command priority: invalid, replace, store, load
    assign do_inval = invalid;
    assign do_fill  = replace && !invalid;
    assign do_store = store && !replace && !invalid && hit;  // Only into a hit line
    assign do_load  = load && !store && !replace && !invalid && hit;
    assign touch    = do_fill || do_store || do_load;

    assign wr_data = do_fill ? din : store_word;

    generate
        for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
            cache_way #(
                .SET_BITS (SET_BITS)
            ) u_way (
                .clk       (clk),
                .rst       (rst),
                .set_idx   (set_idx),
                .word_sel  (word_sel),
                .addr_tag  (addr_tag),
                .wr_data   (wr_data),
                .fill_en   (do_fill && (chosen_way == cache_pkg::way_idx_t'(g))),
                .store_en  (do_store && (chosen_way == cache_pkg::way_idx_t'(g))),
                .inval_en  (do_inval),  // Every way of the set
                .way_hit   (way_hit[g]),
                .way_valid (way_valid[g]),
                .way_dirty (way_dirty[g]),
                .way_tag   (way_tag[g]),
                .way_word  (way_word[g])
            );
        end
    endgenerate

    lru_tracker #(
        .SET_BITS (SET_BITS)
    ) u_lru (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (set_idx),
        .way_hit    (way_hit),
        .touch      (touch),
        .inval      (do_inval),
        .chosen_way (chosen_way)
    );

    data_align u_align (
        .offset     (offset),
        .width_sel  (width_sel),
        .line_word  (line_word),
        .din        (din),
        .load_data  (load_data),
        .store_word (store_word)
    );

    // Hit way, or the victim on a miss
    assign hit       = |way_hit;
    assign valid     = way_valid[chosen_way];
    assign dirty     = way_dirty[chosen_way];
    assign tag       = way_tag[chosen_way];
    assign line_word = way_word[chosen_way];

    assign dout = (load && hit) ? load_data : line_word;  // Raw word for write back

endmodule

// ==== logic/data_align.sv ====
/* Load and store lane alignment
   Extracts and extends byte or half loads, merges byte or half stores */

`timescale 1ns/1ps

module data_align (
    input  logic [cache_pkg::OFFSET_BITS-1:0] offset,
    input  cache_pkg::width_sel_t             width_sel,
    input  cache_pkg::word_t                  line_word,
    input  cache_pkg::word_t                  din,
    output cache_pkg::word_t                  load_data,
    output cache_pkg::word_t                  store_word
);

    logic [4:0]  byte_pos;  // Bit position of the addressed byte
    logic [4:0]  half_pos;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic        is_word;
    logic        is_half;
    logic        is_unsigned;

    assign byte_pos    = {offset, 3'b000};
    assign half_pos    = {offset[1], 4'b0000};
    assign is_word     = width_sel[1];
    assign is_half     = width_sel[0] && !width_sel[1];
    assign is_unsigned = width_sel[2];

    assign ld_byte = line_word[byte_pos +: 8];
    assign ld_half = line_word[half_pos +: 16];

    // Load extraction
    always_comb begin
        if (is_word) begin
            load_data = line_word;
        end else if (is_half) begin
            load_data = {{16{ld_half[15] && !is_unsigned}}, ld_half};
        end else begin
            load_data = {{24{ld_byte[7] && !is_unsigned}}, ld_byte};
        end
    end

    // Store merge, untouched lanes keep the stored word
    always_comb begin
        store_word = line_word;
        if (is_word) begin
            store_word = din;
        end else if (is_half) begin
            store_word[half_pos +: 16] = din[15:0];
        end else begin
            store_word[byte_pos +: 8] = din[7:0];
        end
    end

endmodule

// ==== logic/lru_tracker.sv ====
/* Age based LRU tracker
   Keeps a recency age per way and set, picks the hit or victim way
   and ages the other ways on every access */

`timescale 1ns/1ps

module lru_tracker #(
    parameter int SET_BITS = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [SET_BITS-1:0]           set_idx,
    input  logic [cache_pkg::NUM_WAYS-1:0] way_hit,
    input  logic                          touch,
    input  logic                          inval,
    output cache_pkg::way_idx_t           chosen_way
);

    localparam int NUM_SETS = 2 ** SET_BITS;
    localparam int NUM_WAYS = cache_pkg::NUM_WAYS;

    cache_pkg::age_t age_mem [NUM_SETS][NUM_WAYS];

    cache_pkg::age_t     cur_age  [NUM_WAYS];
    cache_pkg::age_t     next_age [NUM_WAYS];
    cache_pkg::age_t     min_age;
    cache_pkg::age_t     used_age;
    cache_pkg::way_idx_t hit_way;
    cache_pkg::way_idx_t min_way;

    // Ages of the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            cur_age[w] = age_mem[set_idx][w];
        end
    end

    // Way choice
    always_comb begin
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = cache_pkg::way_idx_t'(w);  // Lowest index wins
            end
        end

        min_way = '0;
        min_age = cur_age[0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (cur_age[w] < min_age) begin  // Strict, ties keep lower way
                min_way = cache_pkg::way_idx_t'(w);
                min_age = cur_age[w];
            end
        end

        chosen_way = (|way_hit) ? hit_way : min_way;
    end

    // Accessed way becomes newest, younger ways shift down by one
    always_comb begin
        used_age = cur_age[chosen_way];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (cache_pkg::way_idx_t'(w) == chosen_way) begin
                next_age[w] = cache_pkg::age_t'(cache_pkg::AGE_MAX);
            end else if (cur_age[w] > used_age) begin
                next_age[w] = cur_age[w] - 1'b1;
            end else begin
                next_age[w] = cur_age[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_mem[s][w] <= '0;
                end
            end
        end else if (inval) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                age_mem[set_idx][w] <= '0;  // Whole set back to oldest
            end
        end else if (touch) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                age_mem[set_idx][w] <= next_age[w];
            end
        end
    end

endmodule

// ==== logic/cache_way.sv ====
/* Cache way storage
   Tag, valid, dirty and data words of one way for every set,
   with the tag compare for that way */

`timescale 1ns/1ps

module cache_way #(
    parameter int SET_BITS = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [SET_BITS-1:0]       set_idx,
    input  cache_pkg::word_sel_t      word_sel,
    input  logic [cache_pkg::ADDR_W-SET_BITS-cache_pkg::OFFSET_BITS
                  -cache_pkg::WORD_SEL_BITS-1:0] addr_tag,
    input  cache_pkg::word_t          wr_data,
    input  logic                      fill_en,
    input  logic                      store_en,
    input  logic                      inval_en,
    output logic                      way_hit,
    output logic                      way_valid,
    output logic                      way_dirty,
    output logic [cache_pkg::ADDR_W-SET_BITS-cache_pkg::OFFSET_BITS
                  -cache_pkg::WORD_SEL_BITS-1:0] way_tag,
    output cache_pkg::word_t          way_word
);

    localparam int TAG_W    = cache_pkg::ADDR_W - SET_BITS - cache_pkg::OFFSET_BITS
                              - cache_pkg::WORD_SEL_BITS;
    localparam int NUM_SETS = 2 ** SET_BITS;
    localparam int NUM_WORDS = NUM_SETS * (2 ** cache_pkg::WORD_SEL_BITS);

    logic [NUM_SETS-1:0] valid_r;
    logic [NUM_SETS-1:0] dirty_r;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    cache_pkg::word_t    data_mem [NUM_WORDS];

    logic [SET_BITS+cache_pkg::WORD_SEL_BITS-1:0] word_addr;

    assign word_addr = {set_idx, word_sel};  // Set major, word minor

    // Read side
    assign way_valid = valid_r[set_idx];
    assign way_dirty = dirty_r[set_idx];
    assign way_tag   = tag_mem[set_idx];
    assign way_word  = data_mem[word_addr];
    assign way_hit   = way_valid && (way_tag == addr_tag);

    // Status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
            dirty_r <= '0;
        end else if (inval_en) begin
            valid_r[set_idx] <= 1'b0;
            dirty_r[set_idx] <= 1'b0;
        end else if (fill_en) begin
            valid_r[set_idx] <= 1'b1;  // Fresh line from memory
            dirty_r[set_idx] <= 1'b0;
        end else if (store_en) begin
            dirty_r[set_idx] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[set_idx] <= addr_tag;
        end
        if (fill_en || store_en) begin
            data_mem[word_addr] <= wr_data;  // Merged word on a store
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
/* Cache array shared definitions
   Address field widths, way count and the common vector types */

package cache_pkg;

    // Address and data sizes
    localparam int ADDR_W        = 32;
    localparam int WORD_W        = 32;
    localparam int OFFSET_BITS   = 2;  // Byte within a word
    localparam int WORD_SEL_BITS = 2;  // Word within a line

    // Associativity, fixed by the 2-bit age
    localparam int NUM_WAYS = 4;
    localparam int AGE_MAX  = 3;  // Age of the most recently used way

    // Byte address as seen on the cache port
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // Higher value means more recently used
    typedef logic [1:0] age_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;

    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

    // RV32I load funct3 style access size
    //   bit 1 selects word
    //   bit 0 selects half when bit 1 is clear
    //   bit 2 selects zero extension
    typedef logic [2:0] width_sel_t;

endpackage
